// File: verilog/sine_pkg.sv
// Shared widths and types for the sine pattern generator; referenced by scoped names
package sine_pkg;

    // ------------------------------
    // Sample and table geometry
    // ------------------------------
    parameter int SAMPLE_W = 9;
    parameter int WORD_W   = 4 * SAMPLE_W;
    parameter int WORDS_96 = 24;
    parameter int WORDS_48 = 12;

    // Four samples per word, earliest in the low bits
    typedef logic [WORD_W-1:0] word_t;

    typedef word_t [WORDS_96-1:0] table96_t;
    typedef word_t [WORDS_48-1:0] table48_t;

    // ------------------------------
    // Lane configuration and streams
    // ------------------------------

    // mode 0 plays 96 samples, mode 1 plays 48
    typedef struct packed {
        logic       mode;
        logic [4:0] start;
    } lane_cfg_t;

    // Lane FIFO entry, last flags the final word of a period
    typedef struct packed {
        logic  last;
        word_t data;
    } lane_word_t;

    // Output beat; header beats carry the lane config in data[5:0]
    typedef struct packed {
        logic       sop;
        logic       eop;
        logic [2:0] lane;
        word_t      data;
    } out_beat_t;

endpackage

// File: verilog/sine_table.sv
// Constant sine periods of 96 and 48 samples, packed four samples per word for the lanes
`timescale 1ns/1ps

module sine_table (
    output sine_pkg::table96_t tab96,
    output sine_pkg::table48_t tab48
);

    // ------------------------------
    // 96-sample period, 24 words
    // ------------------------------

    // Rising quarter, samples 0 to 23
    assign tab96[0]  = {9'h131, 9'h120, 9'h110, 9'h0FF};
    assign tab96[1]  = {9'h170, 9'h161, 9'h151, 9'h141};
    assign tab96[2]  = {9'h1A7, 9'h19A, 9'h18D, 9'h17F};
    assign tab96[3]  = {9'h1D3, 9'h1C9, 9'h1BF, 9'h1B3};
    assign tab96[4]  = {9'h1F0, 9'h1EB, 9'h1E4, 9'h1DC};
    assign tab96[5]  = {9'h1FD, 9'h1FC, 9'h1F9, 9'h1F5};

    // Peak at sample 24, then falling back to mid scale
    assign tab96[6]  = {9'h1F9, 9'h1FC, 9'h1FD, 9'h1FE};
    assign tab96[7]  = {9'h1E4, 9'h1EB, 9'h1F0, 9'h1F5};
    assign tab96[8]  = {9'h1BF, 9'h1C9, 9'h1D3, 9'h1DC};
    assign tab96[9]  = {9'h18D, 9'h19A, 9'h1A7, 9'h1B3};
    assign tab96[10] = {9'h151, 9'h161, 9'h170, 9'h17F};
    assign tab96[11] = {9'h110, 9'h120, 9'h131, 9'h141};

    // Negative half starts at sample 48
    assign tab96[12] = {9'h0CD, 9'h0DE, 9'h0EE, 9'h0FF};
    assign tab96[13] = {9'h08E, 9'h09D, 9'h0AD, 9'h0BD};
    assign tab96[14] = {9'h057, 9'h064, 9'h071, 9'h080};
    assign tab96[15] = {9'h02B, 9'h035, 9'h03F, 9'h04B};
    assign tab96[16] = {9'h00E, 9'h013, 9'h01A, 9'h022};
    assign tab96[17] = {9'h001, 9'h002, 9'h005, 9'h009};

    // Trough at sample 72
    assign tab96[18] = {9'h005, 9'h002, 9'h001, 9'h000};
    assign tab96[19] = {9'h01A, 9'h013, 9'h00E, 9'h009};
    assign tab96[20] = {9'h03F, 9'h035, 9'h02B, 9'h022};
    assign tab96[21] = {9'h071, 9'h064, 9'h057, 9'h04B};
    assign tab96[22] = {9'h0AD, 9'h09D, 9'h08E, 9'h080};
    assign tab96[23] = {9'h0EE, 9'h0DE, 9'h0CD, 9'h0BD};

    // ------------------------------
    // 48-sample period, 12 words
    // ------------------------------

    // Every second sample of the long period
    assign tab48[0]  = {9'h161, 9'h141, 9'h120, 9'h0FF};
    assign tab48[1]  = {9'h1C9, 9'h1B3, 9'h19A, 9'h17F};
    assign tab48[2]  = {9'h1FC, 9'h1F5, 9'h1EB, 9'h1DC};

    // Peak at sample 12
    assign tab48[3]  = {9'h1EB, 9'h1F5, 9'h1FC, 9'h1FE};
    assign tab48[4]  = {9'h19A, 9'h1B3, 9'h1C9, 9'h1DC};
    assign tab48[5]  = {9'h120, 9'h141, 9'h161, 9'h17F};

    // Mid scale crossing at sample 24
    assign tab48[6]  = {9'h09D, 9'h0BD, 9'h0DE, 9'h0FF};
    assign tab48[7]  = {9'h035, 9'h04B, 9'h064, 9'h080};
    assign tab48[8]  = {9'h002, 9'h009, 9'h013, 9'h022};

    // Trough at sample 36
    assign tab48[9]  = {9'h013, 9'h009, 9'h002, 9'h000};
    assign tab48[10] = {9'h064, 9'h04B, 9'h035, 9'h022};
    assign tab48[11] = {9'h0DE, 9'h0BD, 9'h09D, 9'h080};

endmodule

// File: verilog/sample_fifo.sv
// Small synchronous FIFO with a type-parameter payload, used by the lanes and the merger
`timescale 1ns/1ps

module sample_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output logic     full,
    output logic     valid,
    output payload_t head
);

    // DEPTH is a power of two, so the pointers wrap on their own
    localparam int PTR_W = $clog2(DEPTH);
    localparam logic [PTR_W:0] FULL_CNT = (PTR_W + 1)'(DEPTH);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign full    = (count == FULL_CNT);
    assign valid   = (count != '0);
    assign do_push = push && !full;
    assign do_pop  = pop && valid;
    assign head    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: verilog/wb_ctrl_regs.sv
// Wishbone classic register slave for the global enable and per-lane period/start settings
`timescale 1ns/1ps

module wb_ctrl_regs #(
    parameter int LANES = 4
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             wb_cyc,
    input  logic                             wb_stb,
    input  logic                             wb_we,
    input  logic [3:0]                       wb_adr,
    input  logic [31:0]                      wb_dat_w,
    output logic [31:0]                      wb_dat_r,
    output logic                             wb_ack,
    output logic                             enable,
    output sine_pkg::lane_cfg_t [LANES-1:0]  lane_cfg
);

    logic        req;
    logic        wr_en;
    logic [31:0] rd_data;

    // New cycle seen while ack is still low
    assign req   = wb_cyc && wb_stb && !wb_ack;
    // Master holds the write through the ack cycle
    assign wr_en = wb_cyc && wb_stb && wb_we && wb_ack;

    // ------------------------------
    // Read decode
    // ------------------------------
    always_comb begin
        rd_data = '0;
        if (wb_adr == 4'd0) begin
            rd_data[0] = enable;
        end
        for (int i = 0; i < LANES; i++) begin
            if (wb_adr == 4'(i + 1)) begin
                rd_data[5:0] = lane_cfg[i];
            end
        end
    end

    // ------------------------------
    // Acknowledge and storage
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;
        end
    end

    // Read data lines up with the ack
    always_ff @(posedge clk) begin
        if (req) begin
            wb_dat_r <= rd_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enable   <= 1'b0;
            lane_cfg <= '0;
        end else if (wr_en) begin
            if (wb_adr == 4'd0) begin
                enable <= wb_dat_w[0];
            end
            for (int i = 0; i < LANES; i++) begin
                if (wb_adr == 4'(i + 1)) begin
                    lane_cfg[i] <= sine_pkg::lane_cfg_t'(wb_dat_w[5:0]);
                end
            end
        end
    end

endmodule

// File: verilog/lane_player.sv
// One lane: walks the selected sine table from its start word and queues tagged words
`timescale 1ns/1ps

module lane_player #(
    parameter int FIFO_DEPTH = 4,
    parameter int LANE_ID    = 0
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  enable,
    input  sine_pkg::lane_cfg_t   cfg,
    input  sine_pkg::table96_t    tab96,
    input  sine_pkg::table48_t    tab48,
    input  logic                  lane_pop,
    output logic                  lane_valid,
    output sine_pkg::lane_word_t  lane_word
);

    // Output beats carry a 3-bit lane number
    if (LANE_ID < 0 || LANE_ID > 7) begin : g_id_range
        $error("lane_player: LANE_ID %0d does not fit the 3-bit lane field", LANE_ID);
    end

    logic                 en_q;
    logic                 rise;
    logic                 run;
    logic                 active;
    logic                 mode_q;
    logic [4:0]           idx;
    logic [4:0]           start_mod;
    logic [4:0]           last_idx;
    logic                 is_last;
    logic                 push;
    logic                 pop;
    logic                 fifo_full;
    logic                 fifo_valid;
    sine_pkg::lane_word_t push_word;

    assign rise   = enable && !en_q;
    // Drops in the same cycle as enable
    assign active = run && enable;

    assign start_mod = cfg.mode ? 5'(cfg.start % sine_pkg::WORDS_48)
                                : 5'(cfg.start % sine_pkg::WORDS_96);
    assign last_idx  = mode_q ? 5'(sine_pkg::WORDS_48 - 1) : 5'(sine_pkg::WORDS_96 - 1);
    assign is_last   = (idx == last_idx);

    assign push_word.last = is_last;
    assign push_word.data = mode_q ? tab48[idx[3:0]] : tab96[idx];

    assign push       = active && !fifo_full;
    // While stopped the lane drains its own FIFO
    assign pop        = active ? lane_pop : 1'b1;
    assign lane_valid = fifo_valid && active;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            en_q   <= 1'b0;
            run    <= 1'b0;
            mode_q <= 1'b0;
            idx    <= '0;
        end else begin
            en_q <= enable;
            // Start only once stale words are gone
            if (!enable) begin
                run <= 1'b0;
            end else if (!run && !fifo_valid) begin
                run <= 1'b1;
            end
            if (rise) begin
                idx    <= start_mod;
                mode_q <= cfg.mode;
            end else if (push) begin
                idx <= is_last ? 5'd0 : idx + 5'd1;
            end
        end
    end

    sample_fifo #(
        .payload_t (sine_pkg::lane_word_t),
        .DEPTH     (FIFO_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (push_word),
        .pop       (pop),
        .full      (fifo_full),
        .valid     (fifo_valid),
        .head      (lane_word)
    );

endmodule

// File: verilog/lane_merger.sv
// Round-robin packetizer: header beat plus one period of words per lane into the output stream
`timescale 1ns/1ps

module lane_merger #(
    parameter int LANES      = 4,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [LANES-1:0]                 lane_valid,
    input  sine_pkg::lane_word_t [LANES-1:0] lane_word,
    input  sine_pkg::lane_cfg_t  [LANES-1:0] lane_cfg,
    input  logic                             out_ready,
    output logic [LANES-1:0]                 lane_pop,
    output logic                             out_valid,
    output sine_pkg::out_beat_t              out_beat
);

    localparam int LANE_W = (LANES > 1) ? $clog2(LANES) : 1;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HEADER,
        ST_BODY
    } state_t;

    state_t              state;
    logic [LANE_W-1:0]   sel;
    logic [LANE_W-1:0]   next_lane;
    logic [LANE_W-1:0]   pick;
    logic                pick_ok;
    logic                push;
    logic                ofifo_full;
    sine_pkg::out_beat_t beat;

    // First valid lane at or after next_lane
    always_comb begin
        int c;
        pick    = next_lane;
        pick_ok = 1'b0;
        for (int k = LANES - 1; k >= 0; k--) begin
            c = (int'(next_lane) + k) % LANES;
            if (lane_valid[c]) begin
                pick    = LANE_W'(c);
                pick_ok = 1'b1;
            end
        end
    end

    // ------------------------------
    // Beat build
    // ------------------------------
    always_comb begin
        beat      = '0;
        beat.lane = 3'(sel);
        push      = 1'b0;
        if (state == ST_HEADER) begin
            beat.sop       = 1'b1;
            beat.data[5:0] = lane_cfg[sel];
            push           = !ofifo_full;
        end else if (state == ST_BODY) begin
            beat.eop  = lane_word[sel].last;
            beat.data = lane_word[sel].data;
            push      = lane_valid[sel] && !ofifo_full;
        end
    end

    assign lane_pop = (state == ST_BODY && push) ? (LANES'(1) << sel) : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            sel       <= '0;
            next_lane <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (pick_ok) begin
                        sel       <= pick;
                        next_lane <= (pick == LANE_W'(LANES - 1)) ? '0 : pick + 1'b1;
                        state     <= ST_HEADER;
                    end
                end
                ST_HEADER: begin
                    if (push) begin
                        state <= ST_BODY;
                    end
                end
                ST_BODY: begin
                    // A lane only runs dry here once it has been disabled
                    if (push && lane_word[sel].last) begin
                        state <= ST_IDLE;
                    end else if (!lane_valid[sel]) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    sample_fifo #(
        .payload_t (sine_pkg::out_beat_t),
        .DEPTH     (FIFO_DEPTH)
    ) u_out_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (beat),
        .pop       (out_ready),
        .full      (ofifo_full),
        .valid     (out_valid),
        .head      (out_beat)
    );

endmodule

// File: verilog/sine_gen_top.sv
// Top of the multi-lane sine pattern generator: registers, table, lanes and merger
`timescale 1ns/1ps

module sine_gen_top #(
    parameter int LANES      = 4,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  logic [3:0]          wb_adr,
    input  logic [31:0]         wb_dat_w,
    output logic [31:0]         wb_dat_r,
    output logic                wb_ack,
    output logic                out_valid,
    output sine_pkg::out_beat_t out_beat,
    input  logic                out_ready
);

    logic                             enable;
    sine_pkg::lane_cfg_t  [LANES-1:0] lane_cfg;
    sine_pkg::table96_t               tab96;
    sine_pkg::table48_t               tab48;
    logic                 [LANES-1:0] lane_valid;
    logic                 [LANES-1:0] lane_pop;
    sine_pkg::lane_word_t [LANES-1:0] lane_word;

    wb_ctrl_regs #(
        .LANES (LANES)
    ) u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .enable   (enable),
        .lane_cfg (lane_cfg)
    );

    sine_table u_table (
        .tab96 (tab96),
        .tab48 (tab48)
    );

    // ------------------------------
    // One player per lane
    // ------------------------------
    for (genvar i = 0; i < LANES; i++) begin : g_lane
        lane_player #(
            .FIFO_DEPTH (FIFO_DEPTH),
            .LANE_ID    (i)
        ) u_player (
            .clk        (clk),
            .rst_n      (rst_n),
            .enable     (enable),
            .cfg        (lane_cfg[i]),
            .tab96      (tab96),
            .tab48      (tab48),
            .lane_pop   (lane_pop[i]),
            .lane_valid (lane_valid[i]),
            .lane_word  (lane_word[i])
        );
    end

    lane_merger #(
        .LANES      (LANES),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_merger (
        .clk        (clk),
        .rst_n      (rst_n),
        .lane_valid (lane_valid),
        .lane_word  (lane_word),
        .lane_cfg   (lane_cfg),
        .out_ready  (out_ready),
        .lane_pop   (lane_pop),
        .out_valid  (out_valid),
        .out_beat   (out_beat)
    );

endmodule

// File: bench/tb_clock.sv
// Free-running testbench clock for the sine generator bench, 4 ns period
`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD_NS = 4.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk = ~clk;
        end
    end

endmodule

// File: bench/sine_gen_tb.sv
// Testbench for sine_gen_top: Wishbone setup, lane packet checks against a sine model, stop test
`timescale 1ns/1ps

module sine_gen_tb;

    localparam int LANES      = 4;
    localparam int FIFO_DEPTH = 4;
    localparam int TARGET     = 4;
    localparam int CLK_NS     = 4;
    // Two streaming phases, worst case a quarter of full throughput
    localparam int PHASE_BEATS     = LANES * TARGET * (sine_pkg::WORDS_96 + 1);
    localparam int WATCHDOG_CYCLES = 2 * PHASE_BEATS * 4 + 3000;

    logic                clk;
    logic                rst_n;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    logic [3:0]          wb_adr;
    logic [31:0]         wb_dat_w;
    logic [31:0]         wb_dat_r;
    logic                wb_ack;
    logic                out_valid;
    sine_pkg::out_beat_t out_beat;
    logic                out_ready = 1'b0;
    logic                rand_ready = 1'b0;
    logic                check_on = 1'b0;

    // Model of the stream the DUT should produce
    sine_pkg::lane_cfg_t [LANES-1:0] cfg_model;
    int                  exp_idx [LANES];
    int                  pkt_count [LANES];
    int                  exp_lane;
    int                  last_hdr_lane;
    bit                  in_pkt;
    bit                  stopping;
    int                  stop_hdrs;
    logic [31:0]         rd_val;
    int                  seed_dummy;

    tb_clock #(.PERIOD_NS(4.0)) u_clk (.clk(clk));

    sine_gen_top #(
        .LANES      (LANES),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .out_valid (out_valid),
        .out_beat  (out_beat),
        .out_ready (out_ready)
    );

    // ------------------------------
    // Reference model and checks
    // ------------------------------
    function automatic int period_words(input logic mode);
        return mode ? sine_pkg::WORDS_48 : sine_pkg::WORDS_96;
    endfunction

    // Sample n of N is round(255 + 255 sin(2 pi n / N))
    function automatic sine_pkg::word_t expected_word(input logic mode, input int idx);
        sine_pkg::word_t w;
        real             v;
        int              n_per;
        int              s;
        n_per = mode ? 48 : 96;
        w     = '0;
        for (s = 0; s < 4; s++) begin
            v = 255.0 + 255.0 * $sin(2.0 * 3.141592653589793 * (idx * 4 + s) / n_per);
            w[s*9 +: 9] = 9'($rtoi($floor(v + 0.5 + 1.0e-6)));
        end
        return w;
    endfunction

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("** Error at %0t: %s (got %0h, expected %0h)", $time, what, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "Check failed");
        end
    endtask

    task automatic check_beat(input sine_pkg::out_beat_t b);
        sine_pkg::lane_cfg_t c;
        int                  per;
        if (!in_pkt) begin
            check_value(b.sop, 1'b1, "sop on header");
            check_value(b.eop, 1'b0, "eop on header");
            check_value(b.lane, exp_lane, "header lane");
            c = cfg_model[exp_lane];
            check_value(b.data, {30'd0, c}, "header config");
            last_hdr_lane = exp_lane;
            // Only the packet already chosen may start once enable is cleared
            if (stopping) begin
                stop_hdrs++;
                check_value(64'(stop_hdrs <= 1), 1, "packets started after enable cleared");
            end
            in_pkt = 1'b1;
        end else begin
            c   = cfg_model[exp_lane];
            per = period_words(c.mode);
            check_value(b.sop, 1'b0, "sop on body");
            check_value(b.lane, exp_lane, "body lane");
            check_value(b.data, expected_word(c.mode, exp_idx[exp_lane]), "body word");
            check_value(b.eop, 64'(exp_idx[exp_lane] == per - 1), "eop position");
            exp_idx[exp_lane] = (exp_idx[exp_lane] + 1) % per;
            if (b.eop) begin
                pkt_count[exp_lane]++;
                in_pkt   = 1'b0;
                exp_lane = (exp_lane + 1) % LANES;
            end
        end
    endtask

    // Compare process, samples mid-cycle where the stream is stable
    always @(negedge clk) begin
        if (rst_n && check_on && out_valid && out_ready) begin
            check_beat(out_beat);
        end
    end

    // Output back-pressure
    initial begin
        seed_dummy = $urandom(32'hc897_bce5);
        forever begin
            @(posedge clk);
            if (!rst_n) begin
                out_ready <= 1'b0;
            end else if (rand_ready) begin
                out_ready <= 1'($urandom & 1);
            end else begin
                out_ready <= 1'b1;
            end
        end
    end

    // ------------------------------
    // Wishbone master
    // ------------------------------
    task automatic wb_cycle(input logic we, input logic [3:0] adr, input logic [31:0] dat);
        int n;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= dat;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > 16) begin
                $display("Wishbone slave did not acknowledge address %0d", adr);
                $display("=== FAIL ===");
                $fatal(1, "No acknowledge");
            end
        end while (!wb_ack);
        rd_val = wb_dat_r;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input logic [3:0] adr, input logic [31:0] dat);
        wb_cycle(1'b1, adr, dat);
    endtask

    task automatic wb_read_check(input logic [3:0] adr, input logic [31:0] exp);
        wb_cycle(1'b0, adr, 32'd0);
        check_value(rd_val, exp, "register read back");
    endtask

    // ------------------------------
    // Phase helpers
    // ------------------------------
    task automatic start_phase(input int first_lane);
        for (int i = 0; i < LANES; i++) begin
            wb_write(4'(i + 1), {26'd0, cfg_model[i]});
            exp_idx[i]   = cfg_model[i].start % period_words(cfg_model[i].mode);
            pkt_count[i] = 0;
        end
        exp_lane = first_lane;
        in_pkt   = 1'b0;
        stopping = 1'b0;
        check_on = 1'b1;
        wb_write(4'd0, 32'd1);
    endtask

    task automatic wait_packets(input int target);
        bit done;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            done = 1'b1;
            for (int i = 0; i < LANES; i++) begin
                if (pkt_count[i] < target) begin
                    done = 1'b0;
                end
            end
        end
    endtask

    // Clear enable, let the output drain, then expect silence
    task automatic stop_and_drain();
        wb_write(4'd0, 32'd0);
        stop_hdrs  = 0;
        stopping   = 1'b1;
        rand_ready = 1'b0;
        // A header chosen just before the stop is pushed one cycle later
        @(negedge clk);
        @(negedge clk);
        while (out_valid) begin
            @(negedge clk);
        end
        repeat (64) begin
            @(negedge clk);
            check_value(out_valid, 1'b0, "out_valid after stop");
        end
    endtask

    initial begin
        #(longint'(WATCHDOG_CYCLES) * CLK_NS);
        $display("Timeout: the run did not finish in the expected time");
        $display("=== FAIL ===");
        $fatal(1, "Watchdog expired");
    end

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        $timeformat(-9, 0, " ns", 0);
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = 4'd0;
        wb_dat_w = 32'd0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        // Register access
        wb_read_check(4'd0, 32'd0);
        wb_write(4'd1, 32'h0000_0025);
        wb_write(4'd4, 32'hffff_ff3a);
        wb_write(4'd9, 32'h0000_003f);
        wb_read_check(4'd1, 32'h0000_0025);
        wb_read_check(4'd4, 32'h0000_003a);
        wb_read_check(4'd9, 32'd0);
        wb_read_check(4'd15, 32'd0);

        // Lane 0 96/0, lane 1 48/5, mixed others, full throughput
        cfg_model[0] = '{mode: 1'b0, start: 5'd0};
        cfg_model[1] = '{mode: 1'b1, start: 5'd5};
        cfg_model[2] = '{mode: 1'b1, start: 5'd0};
        cfg_model[3] = '{mode: 1'b0, start: 5'd10};
        start_phase(0);

        // Enable and lane settings read back while streaming
        wb_read_check(4'd0, 32'd1);
        for (int i = 0; i < LANES; i++) begin
            wb_read_check(4'(i + 1), {26'd0, cfg_model[i]});
        end
        wait_packets(3);
        stop_and_drain();

        // Random back-pressure, starts beyond the period wrap
        cfg_model[0] = '{mode: 1'b1, start: 5'd7};
        cfg_model[1] = '{mode: 1'b0, start: 5'd23};
        cfg_model[2] = '{mode: 1'b0, start: 5'd30};
        cfg_model[3] = '{mode: 1'b1, start: 5'd17};
        rand_ready = 1'b1;
        // Round robin carries on after the last lane served before the stop
        start_phase((last_hdr_lane + 1) % LANES);
        wait_packets(TARGET);
        stop_and_drain();

        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: list.f
verilog/sine_pkg.sv
verilog/sine_table.sv
verilog/sample_fifo.sv
verilog/wb_ctrl_regs.sv
verilog/lane_player.sv
verilog/lane_merger.sv
verilog/sine_gen_top.sv
bench/tb_clock.sv
bench/sine_gen_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the sine generator testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module sine_gen_tb -o sim_tb
if [ $? -ne 0 ]; then
    echo "Compile failed"
    exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "=== PASS ==="; then
    exit 0
fi
exit 1
